// File: hw/pwr_switch_cfg.svh
/*
  Build-time configuration of the power-switch model: latency, domain
  counts and bit layout of the domain vector. Include wherever needed.
*/
`ifndef PWR_SWITCH_CFG_SVH
`define PWR_SWITCH_CFG_SVH

// cycles a switch cell holds back its acknowledge
`define PWR_SWITCH_ACK_LATENCY 15

// domain counts per group
`define PWR_NUM_BANKS          2
`define PWR_NUM_EXT_DOMAINS    1
`define PWR_NUM_DOMAINS        (2 + `PWR_NUM_BANKS + `PWR_NUM_EXT_DOMAINS)

// layout: cpu, peripheral, memory banks, then external domains
`define PWR_CPU_BIT            0
`define PWR_PERIPH_BIT         1
`define PWR_BANK_LSB           2
`define PWR_EXT_LSB            (`PWR_BANK_LSB + `PWR_NUM_BANKS)

`endif

// File: hw/pwr_switch_pkg.sv
/*
  Types shared by the power-switch RTL and its testbench.
  Import into the module header of any file that uses them.
*/
`include "pwr_switch_cfg.svh"

package pwr_switch_pkg;

  // one bit per power domain, active low like the switch requests
  // bit order follows the positions in the cfg header
  typedef logic [`PWR_NUM_DOMAINS-1:0] pwr_dom_vec_t;

  // all domains powered, the state after reset
  localparam pwr_dom_vec_t PWR_ALL_ON = '0;

endpackage

// File: hw/pwr_req_sampler.sv
/*
  Captures the grouped switch requests on the rising clock edge and packs
  them into one domain vector, so that every switch cell sees aligned requests.
*/
`timescale 1ns/1ps

`include "pwr_switch_cfg.svh"

module pwr_req_sampler
  import pwr_switch_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            cpu_switch_n_i,
  input  logic                            periph_switch_n_i,
  input  logic [`PWR_NUM_BANKS-1:0]       bank_switch_n_i,
  input  logic [`PWR_NUM_EXT_DOMAINS-1:0] ext_switch_n_i,
  output pwr_dom_vec_t                    req_vec_o
);

  pwr_dom_vec_t req_vec_d;
  pwr_dom_vec_t req_vec_q;

  // place every group at its slot in the domain vector
  always_comb begin
    req_vec_d                                           = PWR_ALL_ON;
    req_vec_d[`PWR_CPU_BIT]                             = cpu_switch_n_i;
    req_vec_d[`PWR_PERIPH_BIT]                          = periph_switch_n_i;
    req_vec_d[`PWR_BANK_LSB +: `PWR_NUM_BANKS]          = bank_switch_n_i;
    req_vec_d[`PWR_EXT_LSB +: `PWR_NUM_EXT_DOMAINS]     = ext_switch_n_i;
  end

  // rising edge sampling, one cycle of latency
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_vec_q <= PWR_ALL_ON;
    end else begin
      req_vec_q <= req_vec_d;
    end
  end

  assign req_vec_o = req_vec_q;

endmodule

// File: hw/pwr_switch_cell.sv
/*
  Model of one slow power switch. The acknowledge follows the active-low
  switch request after a fixed number of clock cycles.
*/
`timescale 1ns/1ps

`include "pwr_switch_cfg.svh"

module pwr_switch_cell (
  input  logic clk_i,
  input  logic reset_i,
  input  logic switch_n_i,
  output logic ack_n_o
);

  localparam int unsigned STAGES = `PWR_SWITCH_ACK_LATENCY;

  // each stage holds one cycle of request history
  logic [STAGES-1:0] stage_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_q <= '0;
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // short request pulses travel through unchanged
  assign ack_n_o = stage_q[STAGES-1];

endmodule

// File: hw/pwr_ack_monitor.sv
/*
  Watches the switch acknowledges: returns them in their request groups,
  pulses a done flag per domain on every change and flags pending switches.
*/
`timescale 1ns/1ps

`include "pwr_switch_cfg.svh"

module pwr_ack_monitor
  import pwr_switch_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  pwr_dom_vec_t                    req_vec_i,
  input  pwr_dom_vec_t                    ack_vec_i,
  output logic                            cpu_switch_ack_n_o,
  output logic                            periph_switch_ack_n_o,
  output logic [`PWR_NUM_BANKS-1:0]       bank_switch_ack_n_o,
  output logic [`PWR_NUM_EXT_DOMAINS-1:0] ext_switch_ack_n_o,
  output pwr_dom_vec_t                    switch_done_o,
  output logic                            switch_busy_o
);

  pwr_dom_vec_t ack_q;
  pwr_dom_vec_t ack_changed;
  pwr_dom_vec_t done_q;
  pwr_dom_vec_t pending;

  // previous acknowledge value, to spot edges
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= PWR_ALL_ON;
    end else begin
      ack_q <= ack_vec_i;
    end
  end

  assign ack_changed = ack_vec_i ^ ack_q;

  // done lands one cycle after the acknowledge moved
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= '0;
    end else begin
      done_q <= ack_changed;
    end
  end

  assign switch_done_o = done_q;

  // a domain is pending until its acknowledge catches up with the request
  assign pending       = req_vec_i ^ ack_vec_i;
  assign switch_busy_o = |pending;

  // back into request groups
  assign cpu_switch_ack_n_o    = ack_vec_i[`PWR_CPU_BIT];
  assign periph_switch_ack_n_o = ack_vec_i[`PWR_PERIPH_BIT];
  assign bank_switch_ack_n_o   = ack_vec_i[`PWR_BANK_LSB +: `PWR_NUM_BANKS];
  assign ext_switch_ack_n_o    = ack_vec_i[`PWR_EXT_LSB +: `PWR_NUM_EXT_DOMAINS];

endmodule

// File: hw/pwr_switch_emulator.sv
/*
  Top level of the power-switch model: request sampler, one switch cell per
  domain and the acknowledge monitor. Drive the requests and watch the acks.
*/
`timescale 1ns/1ps

`include "pwr_switch_cfg.svh"

module pwr_switch_emulator
  import pwr_switch_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  // active-low switch requests, 0 powers the domain
  input  logic                            cpu_switch_n_i,
  input  logic                            periph_switch_n_i,
  input  logic [`PWR_NUM_BANKS-1:0]       bank_switch_n_i,
  input  logic [`PWR_NUM_EXT_DOMAINS-1:0] ext_switch_n_i,
  // acknowledges, delayed copies of the requests
  output logic                            cpu_switch_ack_n_o,
  output logic                            periph_switch_ack_n_o,
  output logic [`PWR_NUM_BANKS-1:0]       bank_switch_ack_n_o,
  output logic [`PWR_NUM_EXT_DOMAINS-1:0] ext_switch_ack_n_o,
  output pwr_dom_vec_t                    switch_done_o,
  output logic                            switch_busy_o
);

  pwr_dom_vec_t req_vec;
  pwr_dom_vec_t ack_vec;

  pwr_req_sampler pwr_req_sampler_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .cpu_switch_n_i    (cpu_switch_n_i),
    .periph_switch_n_i (periph_switch_n_i),
    .bank_switch_n_i   (bank_switch_n_i),
    .ext_switch_n_i    (ext_switch_n_i),
    .req_vec_o         (req_vec)
  );

  // one slow switch per domain
  for (genvar d = 0; d < `PWR_NUM_DOMAINS; d++) begin : gen_cell
    pwr_switch_cell pwr_switch_cell_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .switch_n_i (req_vec[d]),
      .ack_n_o    (ack_vec[d])
    );
  end

  pwr_ack_monitor pwr_ack_monitor_inst (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .req_vec_i             (req_vec),
    .ack_vec_i             (ack_vec),
    .cpu_switch_ack_n_o    (cpu_switch_ack_n_o),
    .periph_switch_ack_n_o (periph_switch_ack_n_o),
    .bank_switch_ack_n_o   (bank_switch_ack_n_o),
    .ext_switch_ack_n_o    (ext_switch_ack_n_o),
    .switch_done_o         (switch_done_o),
    .switch_busy_o         (switch_busy_o)
  );

endmodule

// File: verification/pwr_switch_checker.sv
/*
  Scoreboard for the power-switch model. Keeps a history of the sampled
  requests and compares acks, done pulses and busy on every rising edge.
*/
`timescale 1ns/1ps

`include "pwr_switch_cfg.svh"

module pwr_switch_checker
  import pwr_switch_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            cpu_switch_n_i,
  input  logic                            periph_switch_n_i,
  input  logic [`PWR_NUM_BANKS-1:0]       bank_switch_n_i,
  input  logic [`PWR_NUM_EXT_DOMAINS-1:0] ext_switch_n_i,
  input  logic                            cpu_switch_ack_n_i,
  input  logic                            periph_switch_ack_n_i,
  input  logic [`PWR_NUM_BANKS-1:0]       bank_switch_ack_n_i,
  input  logic [`PWR_NUM_EXT_DOMAINS-1:0] ext_switch_ack_n_i,
  input  pwr_dom_vec_t                    switch_done_i,
  input  logic                            switch_busy_i,
  input  int                              test_id_i,
  input  logic                            run_done_i,
  output int                              error_count_o
);

  localparam int LAT   = `PWR_SWITCH_ACK_LATENCY;
  localparam int DEPTH = LAT + 3;

  // hist[i] holds the request value taken i+1 edges ago
  pwr_dom_vec_t hist [DEPTH];
  int   cur_test;
  int   test_checks;
  int   test_errors;
  int   total_checks;
  int   total_errors;
  int   tests_run;
  logic closed;

  function automatic pwr_dom_vec_t pack_groups(input logic cpu, input logic periph,
                                               input logic [`PWR_NUM_BANKS-1:0] bank,
                                               input logic [`PWR_NUM_EXT_DOMAINS-1:0] ext);
    pwr_dom_vec_t v;
    v = '0;
    v[`PWR_CPU_BIT]                         = cpu;
    v[`PWR_PERIPH_BIT]                      = periph;
    v[`PWR_BANK_LSB +: `PWR_NUM_BANKS]      = bank;
    v[`PWR_EXT_LSB +: `PWR_NUM_EXT_DOMAINS] = ext;
    return v;
  endfunction

  // ack repeats the input from LAT+1 edges back, done marks its edges
  function automatic void expected_outputs(input pwr_dom_vec_t sampled,
                                           input pwr_dom_vec_t in_lat,
                                           input pwr_dom_vec_t in_lat1,
                                           input pwr_dom_vec_t in_lat2,
                                           output pwr_dom_vec_t exp_ack,
                                           output pwr_dom_vec_t exp_done,
                                           output logic exp_busy);
    exp_ack  = in_lat;
    exp_done = in_lat1 ^ in_lat2;
    exp_busy = (sampled != in_lat);
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset";
      2:       return "single domain";
      3:       return "done pulse";
      4:       return "busy level";
      5:       return "random traffic";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_test();
    $display("test %0d %s: %0d checks, %0d errors",
             cur_test, test_name(cur_test), test_checks, test_errors);
    tests_run++;
  endtask

  task automatic flag(input string what, input logic [31:0] exp, input logic [31:0] got);
    $display("Error %0t: %s expected %b got %b", $time, what, exp, got);
    test_errors++;
    total_errors++;
  endtask

  initial begin
    for (int i = 0; i < DEPTH; i++) hist[i] = '0;
    cur_test     = 0;
    test_checks  = 0;
    test_errors  = 0;
    total_checks = 0;
    total_errors = 0;
    tests_run    = 0;
    closed       = 1'b0;
  end

  always @(posedge clk_i) begin
    pwr_dom_vec_t got_ack;
    pwr_dom_vec_t exp_ack;
    pwr_dom_vec_t exp_done;
    logic         exp_busy;
    if (test_id_i != cur_test) begin
      if (cur_test > 0) report_test();
      cur_test    = test_id_i;
      test_checks = 0;
      test_errors = 0;
    end
    if (!reset_i && !closed) begin
      expected_outputs(hist[0], hist[LAT], hist[LAT+1], hist[LAT+2],
                       exp_ack, exp_done, exp_busy);
      got_ack = pack_groups(cpu_switch_ack_n_i, periph_switch_ack_n_i,
                            bank_switch_ack_n_i, ext_switch_ack_n_i);
      if (got_ack !== exp_ack) flag("ack", 32'(exp_ack), 32'(got_ack));
      if (switch_done_i !== exp_done) flag("done", 32'(exp_done), 32'(switch_done_i));
      if (switch_busy_i !== exp_busy) flag("busy", 32'(exp_busy), 32'(switch_busy_i));
      test_checks++;
      total_checks++;
    end
    for (int i = DEPTH - 1; i > 0; i--) hist[i] = hist[i-1];
    // the sampler holds zero while in reset
    hist[0] = reset_i ? '0 : pack_groups(cpu_switch_n_i, periph_switch_n_i,
                                         bank_switch_n_i, ext_switch_n_i);
    if (run_done_i && !closed) begin
      closed = 1'b1;
      if (cur_test > 0) report_test();
      $display("tests %0d, checks %0d, errors %0d", tests_run, total_checks, total_errors);
    end
  end

  assign error_count_o = total_errors;

endmodule

// File: verification/pwr_switch_asserts.sv
/*
  Concurrent assertions on the power-switch top level, attached by bind.
*/
`timescale 1ns/1ps

`include "pwr_switch_cfg.svh"

module pwr_switch_asserts
  import pwr_switch_pkg::*;
(
  input logic         clk_i,
  input logic         reset_i,
  input pwr_dom_vec_t req_vec_i,
  input pwr_dom_vec_t ack_vec_i,
  input pwr_dom_vec_t switch_done_i,
  input logic         switch_busy_i
);

  localparam int LAT = `PWR_SWITCH_ACK_LATENCY;

  // a done bit never stays high two cycles running
  done_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    (switch_done_i & $past(switch_done_i)) == '0)
    else $error("done pulse longer than one cycle");

  // acks repeat the requests from one latency back, so equal values leave nothing pending
  busy_low_when_matched: assert property (@(posedge clk_i) disable iff (reset_i)
    (req_vec_i == $past(req_vec_i, LAT)) |-> !switch_busy_i)
    else $error("busy high although the acks have caught up with the requests");

  outputs_zero_in_reset: assert property (@(posedge clk_i)
    reset_i |=> (ack_vec_i == '0 && switch_done_i == '0 && !switch_busy_i))
    else $error("outputs not cleared by reset");

endmodule

bind pwr_switch_emulator pwr_switch_asserts pwr_switch_asserts_inst (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .req_vec_i     (req_vec),
  .ack_vec_i     (ack_vec),
  .switch_done_i (switch_done_o),
  .switch_busy_i (switch_busy_o)
);

// File: verification/tb_pwr_switch.sv
/*
  Testbench top for the power-switch model. Runs reset, directed switch
  sequences and LFSR traffic while the checker compares every cycle.
*/
`timescale 1ns/1ps

`include "pwr_switch_cfg.svh"

module tb_pwr_switch
  import pwr_switch_pkg::*;
();

  localparam int LAT          = `PWR_SWITCH_ACK_LATENCY;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam int RAND_CYCLES  = 300;
  // worst case for one request change to settle, including the done pulse
  localparam int SETTLE       = LAT + 8;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 10 * SETTLE + RAND_CYCLES + 10;

  logic                            clk_i;
  logic                            reset_i;
  logic                            cpu_switch_n_i;
  logic                            periph_switch_n_i;
  logic [`PWR_NUM_BANKS-1:0]       bank_switch_n_i;
  logic [`PWR_NUM_EXT_DOMAINS-1:0] ext_switch_n_i;
  logic                            cpu_switch_ack_n_o;
  logic                            periph_switch_ack_n_o;
  logic [`PWR_NUM_BANKS-1:0]       bank_switch_ack_n_o;
  logic [`PWR_NUM_EXT_DOMAINS-1:0] ext_switch_ack_n_o;
  pwr_dom_vec_t                    switch_done_o;
  logic                            switch_busy_o;

  int           test_id;
  logic         run_done;
  int           error_count;
  logic [15:0]  lfsr_state;
  pwr_dom_vec_t req_now;

  pwr_switch_emulator pwr_switch_emulator_inst (.*);

  pwr_switch_checker checker_inst (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .cpu_switch_n_i        (cpu_switch_n_i),
    .periph_switch_n_i     (periph_switch_n_i),
    .bank_switch_n_i       (bank_switch_n_i),
    .ext_switch_n_i        (ext_switch_n_i),
    .cpu_switch_ack_n_i    (cpu_switch_ack_n_o),
    .periph_switch_ack_n_i (periph_switch_ack_n_o),
    .bank_switch_ack_n_i   (bank_switch_ack_n_o),
    .ext_switch_ack_n_i    (ext_switch_ack_n_o),
    .switch_done_i         (switch_done_o),
    .switch_busy_i         (switch_busy_o),
    .test_id_i             (test_id),
    .run_done_i            (run_done),
    .error_count_o         (error_count)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_state = next_lfsr(lfsr_state);
    b = lfsr_state[0];
  endtask

  // call right after a rising edge
  task automatic drive_requests(input pwr_dom_vec_t v);
    req_now           = v;
    cpu_switch_n_i    <= v[`PWR_CPU_BIT];
    periph_switch_n_i <= v[`PWR_PERIPH_BIT];
    bank_switch_n_i   <= v[`PWR_BANK_LSB +: `PWR_NUM_BANKS];
    ext_switch_n_i    <= v[`PWR_EXT_LSB +: `PWR_NUM_EXT_DOMAINS];
  endtask

  // busy is sampled on the falling edge where it is stable
  task automatic wait_idle();
    repeat (3) @(negedge clk_i);
    while (switch_busy_o) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
  endtask

  task automatic apply_change(input pwr_dom_vec_t v);
    @(posedge clk_i);
    drive_requests(v);
    wait_idle();
  endtask

  task automatic run_random();
    pwr_dom_vec_t vec;
    pwr_dom_vec_t flipped_last;
    logic b0;
    logic b1;
    vec          = req_now;
    flipped_last = '0;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(posedge clk_i);
      for (int d = 0; d < `PWR_NUM_DOMAINS; d++) begin
        take_bit(b0);
        take_bit(b1);
        // no back to back flips, so a pulse is at least two cycles wide
        if (b0 && b1 && !flipped_last[d]) begin
          vec[d]          = ~vec[d];
          flipped_last[d] = 1'b1;
        end else begin
          flipped_last[d] = 1'b0;
        end
      end
      drive_requests(vec);
    end
    apply_change('0);
  endtask

  initial begin
    clk_i             = 1'b0;
    reset_i           = 1'b1;
    cpu_switch_n_i    = 1'b0;
    periph_switch_n_i = 1'b0;
    bank_switch_n_i   = '0;
    ext_switch_n_i    = '0;
    test_id           = 0;
    run_done          = 1'b0;
    req_now           = '0;
    lfsr_state        = 16'd48114;

    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    test_id <= 1;
    repeat (LAT + 4) @(posedge clk_i);

    // one bank switched off, then the cpu as well
    test_id <= 2;
    apply_change(pwr_dom_vec_t'(1) << `PWR_BANK_LSB);
    test_id <= 3;
    apply_change(req_now | (pwr_dom_vec_t'(1) << `PWR_CPU_BIT));
    apply_change(req_now & ~(pwr_dom_vec_t'(1) << `PWR_BANK_LSB));

    test_id <= 4;
    apply_change(req_now | (pwr_dom_vec_t'(1) << `PWR_PERIPH_BIT)
                         | (pwr_dom_vec_t'(1) << `PWR_EXT_LSB));
    apply_change('0);

    test_id <= 5;
    run_random();

    @(posedge clk_i);
    run_done <= 1'b1;
    repeat (2) @(posedge clk_i);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // bound derived from the test lengths
  initial begin
    #(CLK_PERIOD * (TOTAL_CYCLES + 4 * LAT));
    $display("watchdog expired before the tests completed");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: build.f
+incdir+hw
hw/pwr_switch_pkg.sv
hw/pwr_req_sampler.sv
hw/pwr_switch_cell.sv
hw/pwr_ack_monitor.sv
hw/pwr_switch_emulator.sv
verification/pwr_switch_checker.sv
verification/pwr_switch_asserts.sv
verification/tb_pwr_switch.sv

// File: Makefile
# Verilator build and run of the power-switch model

VERILATOR ?= verilator
TOP       ?= tb_pwr_switch
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= FAIL: see errors above

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
